/* source/cpu_pkg.sv */
package cpu_pkg;

    localparam int word_size = 16;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_JAL   = 4'd10,
        OP_RTYPE = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_JPR = 6'd25,
        FN_JRL = 6'd26,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_e;

    // first eight follow the func encoding
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_NOT    = 4'd4,
        ALU_TCP    = 4'd5,
        ALU_SHL    = 4'd6,
        ALU_SHR    = 4'd7,
        ALU_PASS_B = 4'd8
    } alu_op_e;

    localparam logic [1:0] link_reg = 2'd2;  // jal / jrl destination

    // instruction fields
    localparam int op_hi     = 15;
    localparam int op_lo     = 12;
    localparam int rs_hi     = 11;
    localparam int rs_lo     = 10;
    localparam int rt_hi     = 9;
    localparam int rt_lo     = 8;
    localparam int rd_hi     = 7;
    localparam int rd_lo     = 6;
    localparam int func_hi   = 5;
    localparam int func_lo   = 0;
    localparam int imm_hi    = 7;
    localparam int imm_lo    = 0;
    localparam int target_hi = 11;
    localparam int target_lo = 0;

endpackage

/* source/register_file.sv */
module register_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [1:0]                    rs_addr,
    input  logic [1:0]                    rt_addr,
    input  logic [1:0]                    wr_addr,
    input  logic [cpu_pkg::word_size-1:0] wr_data,
    input  logic                          wr_en,
    output logic [cpu_pkg::word_size-1:0] rs_data,
    output logic [cpu_pkg::word_size-1:0] rt_data
);

    logic [cpu_pkg::word_size-1:0] regs [4];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // same-cycle write shows up on the read side
    assign rs_data = (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
    assign rt_data = (wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

/* source/alu.sv */
module alu (
    input  logic [cpu_pkg::word_size-1:0] a,
    input  logic [cpu_pkg::word_size-1:0] b,
    input  cpu_pkg::alu_op_e              op,
    output logic [cpu_pkg::word_size-1:0] result
);

    import cpu_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;  // also adi and address generation
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_NOT:    result = ~a;
            ALU_TCP:    result = ~a + 1'b1;
            ALU_SHL:    result = {a[word_size-2:0], 1'b0};
            ALU_SHR:    result = {a[word_size-1], a[word_size-1:1]};  // sign kept
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

/* source/control_unit.sv */
module control_unit (
    input  logic [cpu_pkg::word_size-1:0] instr,
    input  logic [cpu_pkg::word_size-1:0] pc_id,
    input  logic [cpu_pkg::word_size-1:0] rs_val,
    input  logic [cpu_pkg::word_size-1:0] rt_val,
    input  logic                          stalled,
    output cpu_pkg::alu_op_e              alu_op,
    output logic                          alu_src_imm,
    output logic                          mem_rd,
    output logic                          mem_wr,
    output logic                          reg_wr,
    output logic                          mem_to_reg,
    output logic                          is_wwd,
    output logic                          is_halt,
    output logic                          link,
    output logic [1:0]                    dest,
    output logic [cpu_pkg::word_size-1:0] imm_val,
    output logic                          uses_rs,
    output logic                          uses_rt,
    output logic                          redirect,
    output logic [cpu_pkg::word_size-1:0] target
);

    import cpu_pkg::*;

    opcode_e              op;
    func_e                fn;
    logic [7:0]           imm_f;
    logic [word_size-1:0] pc_plus1;
    logic                 take;

    assign op       = opcode_e'(instr[op_hi:op_lo]);
    assign fn       = func_e'(instr[func_hi:func_lo]);
    assign imm_f    = instr[imm_hi:imm_lo];
    assign pc_plus1 = pc_id + 1'b1;

    always_comb begin
        case (op)
            OP_ORI:   imm_val = {{(word_size-8){1'b0}}, imm_f};
            OP_LHI:   imm_val = {imm_f, {(word_size-8){1'b0}}};
            OP_RTYPE: imm_val = '0;  // lets wwd pass rs through the adder
            default:  imm_val = {{(word_size-8){imm_f[7]}}, imm_f};
        endcase
    end

    always_comb begin
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        mem_rd      = 1'b0;
        mem_wr      = 1'b0;
        reg_wr      = 1'b0;
        mem_to_reg  = 1'b0;
        is_wwd      = 1'b0;
        is_halt     = 1'b0;
        link        = 1'b0;
        dest        = instr[rt_hi:rt_lo];  // i-type default
        uses_rs     = 1'b0;
        uses_rt     = 1'b0;
        take        = 1'b0;
        target      = pc_plus1 + imm_val;
        case (op)
            OP_BNE, OP_BEQ: begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                take    = (rs_val == rt_val) ^ (op == OP_BNE);
            end
            OP_ADI, OP_ORI, OP_LHI, OP_LWD: begin
                alu_op      = (op == OP_ORI) ? ALU_OR : (op == OP_LHI) ? ALU_PASS_B : ALU_ADD;
                alu_src_imm = 1'b1;
                reg_wr      = 1'b1;
                uses_rs     = (op != OP_LHI);
                mem_rd      = (op == OP_LWD);
                mem_to_reg  = (op == OP_LWD);
            end
            OP_SWD: begin
                alu_src_imm = 1'b1;
                mem_wr      = 1'b1;
                uses_rs     = 1'b1;
                uses_rt     = 1'b1;
            end
            OP_JMP, OP_JAL: begin
                take   = 1'b1;
                target = {pc_id[word_size-1:target_hi+1], instr[target_hi:target_lo]};
                reg_wr = (op == OP_JAL);
                link   = (op == OP_JAL);
                dest   = link_reg;
            end
            OP_RTYPE: begin
                dest    = instr[rd_hi:rd_lo];
                uses_rs = 1'b1;
                case (fn)
                    FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
                        alu_op  = alu_op_e'(fn[3:0]);
                        reg_wr  = 1'b1;
                        uses_rt = fn inside {FN_ADD, FN_SUB, FN_AND, FN_ORR};
                    end
                    FN_JPR, FN_JRL: begin
                        take   = 1'b1;
                        target = rs_val;
                        reg_wr = (fn == FN_JRL);
                        link   = (fn == FN_JRL);
                        dest   = link_reg;
                    end
                    FN_WWD: begin
                        is_wwd      = 1'b1;
                        alu_src_imm = 1'b1;
                    end
                    FN_HLT: begin
                        is_halt = 1'b1;
                        uses_rs = 1'b0;
                    end
                    default: uses_rs = 1'b0;
                endcase
            end
            default: ;  // unused opcodes retire as no-ops
        endcase
    end

    assign redirect = take && !stalled;

endmodule

/* source/hazard_unit.sv */
module hazard_unit (
    input  logic [1:0] rs,
    input  logic [1:0] rt,
    input  logic       uses_rs,
    input  logic       uses_rt,
    input  logic [1:0] ex_dest,
    input  logic       ex_reg_wr,
    input  logic       ex_valid,
    input  logic [1:0] mem_dest,
    input  logic       mem_reg_wr,
    input  logic       mem_valid,
    input  logic       redirect,
    output logic       stall,
    output logic       flush
);

    logic ex_hit;
    logic mem_hit;

    // wb conflicts are covered by register file write-through
    assign ex_hit = ex_valid && ex_reg_wr &&
                    ((uses_rs && rs == ex_dest) || (uses_rt && rt == ex_dest));
    assign mem_hit = mem_valid && mem_reg_wr &&
                     ((uses_rs && rs == mem_dest) || (uses_rt && rt == mem_dest));

    assign stall = ex_hit || mem_hit;
    assign flush = redirect;

endmodule

/* source/pipeline_datapath.sv */
module pipeline_datapath #(
    parameter logic [cpu_pkg::word_size-1:0] reset_pc = '0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic [cpu_pkg::word_size-1:0] imem_addr,
    input  logic [cpu_pkg::word_size-1:0] imem_data,
    output logic                          dmem_rd,
    output logic                          dmem_wr,
    output logic [cpu_pkg::word_size-1:0] dmem_addr,
    output logic [cpu_pkg::word_size-1:0] dmem_wdata,
    input  logic [cpu_pkg::word_size-1:0] dmem_rdata,
    output logic [cpu_pkg::word_size-1:0] out_port,
    output logic                          out_valid,
    output logic [cpu_pkg::word_size-1:0] num_inst,
    output logic                          is_halted
);

    import cpu_pkg::*;

    logic [word_size-1:0] pc;
    logic                 fetch_stop;
    logic                 halted_q;

    logic                 if_id_valid;
    logic [word_size-1:0] if_id_pc;
    logic [word_size-1:0] if_id_instr;

    // decode
    logic [word_size-1:0] rs_val, rt_val, imm_val, target;
    alu_op_e              id_alu_op;
    logic                 id_alu_src_imm, id_mem_rd, id_mem_wr, id_reg_wr, id_mem_to_reg;
    logic                 id_is_wwd, id_is_halt, id_link;
    logic [1:0]           id_dest;
    logic                 uses_rs, uses_rt, redirect, stall, flush, id_hold, id_halt;

    logic                 id_ex_valid;
    alu_op_e              id_ex_alu_op;
    logic                 id_ex_alu_src_imm, id_ex_mem_rd, id_ex_mem_wr, id_ex_reg_wr;
    logic                 id_ex_mem_to_reg, id_ex_is_wwd, id_ex_is_halt, id_ex_link;
    logic [1:0]           id_ex_dest;
    logic [word_size-1:0] id_ex_a, id_ex_b, id_ex_imm, id_ex_link_val;
    logic [word_size-1:0] alu_b, alu_result;

    logic                 ex_mem_valid;
    logic                 ex_mem_mem_rd, ex_mem_mem_wr, ex_mem_reg_wr, ex_mem_mem_to_reg;
    logic                 ex_mem_is_wwd, ex_mem_is_halt, ex_mem_link;
    logic [1:0]           ex_mem_dest;
    logic [word_size-1:0] ex_mem_result, ex_mem_store, ex_mem_link_val;

    logic                 mem_wb_valid;
    logic                 mem_wb_reg_wr, mem_wb_mem_to_reg, mem_wb_is_wwd, mem_wb_is_halt;
    logic                 mem_wb_link;
    logic [1:0]           mem_wb_dest;
    logic [word_size-1:0] mem_wb_result, mem_wb_rdata, mem_wb_link_val, wb_data;

    register_file u_register_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (if_id_instr[rs_hi:rs_lo]),
        .rt_addr (if_id_instr[rt_hi:rt_lo]),
        .wr_addr (mem_wb_dest),
        .wr_data (wb_data),
        .wr_en   (mem_wb_valid && mem_wb_reg_wr),
        .rs_data (rs_val),
        .rt_data (rt_val)
    );

    assign id_hold = stall || !if_id_valid;  // no redirect from a bubble

    control_unit u_control_unit (
        .instr       (if_id_instr),
        .pc_id       (if_id_pc),
        .rs_val      (rs_val),
        .rt_val      (rt_val),
        .stalled     (id_hold),
        .alu_op      (id_alu_op),
        .alu_src_imm (id_alu_src_imm),
        .mem_rd      (id_mem_rd),
        .mem_wr      (id_mem_wr),
        .reg_wr      (id_reg_wr),
        .mem_to_reg  (id_mem_to_reg),
        .is_wwd      (id_is_wwd),
        .is_halt     (id_is_halt),
        .link        (id_link),
        .dest        (id_dest),
        .imm_val     (imm_val),
        .uses_rs     (uses_rs),
        .uses_rt     (uses_rt),
        .redirect    (redirect),
        .target      (target)
    );

    hazard_unit u_hazard_unit (
        .rs         (if_id_instr[rs_hi:rs_lo]),
        .rt         (if_id_instr[rt_hi:rt_lo]),
        .uses_rs    (uses_rs && if_id_valid),
        .uses_rt    (uses_rt && if_id_valid),
        .ex_dest    (id_ex_dest),
        .ex_reg_wr  (id_ex_reg_wr),
        .ex_valid   (id_ex_valid),
        .mem_dest   (ex_mem_dest),
        .mem_reg_wr (ex_mem_reg_wr),
        .mem_valid  (ex_mem_valid),
        .redirect   (redirect),
        .stall      (stall),
        .flush      (flush)
    );

    assign id_halt = if_id_valid && id_is_halt && !stall;

    assign alu_b = id_ex_alu_src_imm ? id_ex_imm : id_ex_b;

    alu u_alu (
        .a      (id_ex_a),
        .b      (alu_b),
        .op     (id_ex_alu_op),
        .result (alu_result)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= reset_pc;
            fetch_stop   <= 1'b0;
            if_id_valid  <= 1'b0;
            id_ex_valid  <= 1'b0;
            ex_mem_valid <= 1'b0;
            mem_wb_valid <= 1'b0;
            halted_q     <= 1'b0;
            num_inst     <= '0;
        end else begin
            if (!stall && !fetch_stop && !id_halt) begin
                pc <= redirect ? target : pc + 1'b1;
            end
            if (id_halt) begin
                fetch_stop <= 1'b1;
            end
            if (!stall) begin
                if_id_valid <= !(flush || id_halt || fetch_stop);
            end
            id_ex_valid  <= if_id_valid && !stall;  // bubble while stalled
            ex_mem_valid <= id_ex_valid;
            mem_wb_valid <= ex_mem_valid;
            if (mem_wb_valid) begin
                num_inst <= num_inst + 1'b1;
                if (mem_wb_is_halt) begin
                    halted_q <= 1'b1;
                end
            end
        end
    end

    // qualified by the valid bits above
    always_ff @(posedge clk) begin
        if (!stall) begin
            if_id_pc    <= pc;
            if_id_instr <= imem_data;
        end
        id_ex_alu_op      <= id_alu_op;
        id_ex_alu_src_imm <= id_alu_src_imm;
        id_ex_mem_rd      <= id_mem_rd;
        id_ex_mem_wr      <= id_mem_wr;
        id_ex_reg_wr      <= id_reg_wr;
        id_ex_mem_to_reg  <= id_mem_to_reg;
        id_ex_is_wwd      <= id_is_wwd;
        id_ex_is_halt     <= id_is_halt;
        id_ex_link        <= id_link;
        id_ex_dest        <= id_dest;
        id_ex_a           <= rs_val;
        id_ex_b           <= rt_val;
        id_ex_imm         <= imm_val;
        id_ex_link_val    <= if_id_pc + 1'b1;

        ex_mem_mem_rd     <= id_ex_mem_rd;
        ex_mem_mem_wr     <= id_ex_mem_wr;
        ex_mem_reg_wr     <= id_ex_reg_wr;
        ex_mem_mem_to_reg <= id_ex_mem_to_reg;
        ex_mem_is_wwd     <= id_ex_is_wwd;
        ex_mem_is_halt    <= id_ex_is_halt;
        ex_mem_link       <= id_ex_link;
        ex_mem_dest       <= id_ex_dest;
        ex_mem_result     <= alu_result;
        ex_mem_store      <= id_ex_b;
        ex_mem_link_val   <= id_ex_link_val;

        mem_wb_reg_wr     <= ex_mem_reg_wr;
        mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
        mem_wb_is_wwd     <= ex_mem_is_wwd;
        mem_wb_is_halt    <= ex_mem_is_halt;
        mem_wb_link       <= ex_mem_link;
        mem_wb_dest       <= ex_mem_dest;
        mem_wb_result     <= ex_mem_result;
        mem_wb_rdata      <= dmem_rdata;
        mem_wb_link_val   <= ex_mem_link_val;
    end

    assign imem_addr  = pc;
    assign dmem_rd    = ex_mem_valid && ex_mem_mem_rd;
    assign dmem_wr    = ex_mem_valid && ex_mem_mem_wr;
    assign dmem_addr  = ex_mem_result;
    assign dmem_wdata = ex_mem_store;

    assign wb_data = mem_wb_mem_to_reg ? mem_wb_rdata :
                     mem_wb_link       ? mem_wb_link_val : mem_wb_result;

    assign out_port  = mem_wb_result;  // rs + 0 for wwd
    assign out_valid = mem_wb_valid && mem_wb_is_wwd;
    assign is_halted = halted_q || (mem_wb_valid && mem_wb_is_halt);

endmodule

/* source/cpu_top.sv */
module cpu_top #(
    parameter logic [cpu_pkg::word_size-1:0] reset_pc = '0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic [cpu_pkg::word_size-1:0] imem_addr,
    input  logic [cpu_pkg::word_size-1:0] imem_data,
    output logic                          dmem_rd,
    output logic                          dmem_wr,
    output logic [cpu_pkg::word_size-1:0] dmem_addr,
    output logic [cpu_pkg::word_size-1:0] dmem_wdata,
    input  logic [cpu_pkg::word_size-1:0] dmem_rdata,
    output logic [cpu_pkg::word_size-1:0] out_port,
    output logic                          out_valid,
    output logic [cpu_pkg::word_size-1:0] num_inst,
    output logic                          is_halted
);

    pipeline_datapath #(
        .reset_pc (reset_pc)
    ) u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_rd    (dmem_rd),
        .dmem_wr    (dmem_wr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .out_port   (out_port),
        .out_valid  (out_valid),
        .num_inst   (num_inst),
        .is_halted  (is_halted)
    );

endmodule

/* bench/cpu_tb.sv */
module cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import cpu_pkg::*;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic [15:0] imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata, out_port, num_inst;
    logic        dmem_rd, dmem_wr, out_valid, is_halted;

    logic [15:0] rom [256];
    logic [15:0] ram [256];
    logic [15:0] exp_ram [256];
    logic [15:0] exp_out [$];
    int          exp_count, out_idx, plen;
    int          cycles = 0;
    int          cycle_limit = 100;  // grows by 4 cycles per loaded instruction
    logic [31:0] lfsr = 32'h640c;
    string       test_name;

    cpu_top #(.reset_pc(16'h0000)) DUT (.*);

    always #2 clk = ~clk;

    assign imem_data  = rom[imem_addr[7:0]];
    assign dmem_rdata = dmem_rd ? ram[dmem_addr[7:0]] : 16'hdead;  // valid only on a read

    function automatic logic [15:0] fill_word(input int a);
        return {a[7:0] ^ 8'h5a, a[7:0]};
    endfunction

    // image reloads while the core sits in reset
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) ram[i] <= fill_word(i);
        end else if (dmem_wr) begin
            ram[dmem_addr[7:0]] <= dmem_wdata;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string label, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("Fail %s %s: expected %0h, actual %0h",
                                test_name, label, expected, actual));
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) abort_run("the run did not finish within its cycle limit");
    end

    // output monitor, one expected value per wwd
    always @(posedge clk) begin
        if (!rst_n) begin
            out_idx <= 0;
        end else if (out_valid) begin
            if (out_idx >= exp_out.size()) begin
                abort_run($sformatf("unexpected WWD output %0h in test %s", out_port, test_name));
            end else begin
                check($sformatf("wwd[%0d]", out_idx), 32'(exp_out[out_idx]), 32'(out_port));
                out_idx <= out_idx + 1;
            end
        end
    end

    function automatic logic [7:0] rand_byte();
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // taps 32 22 2 1
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [15:0] itype(input logic [3:0] op, input logic [1:0] rs,
                                          input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] rtype(input logic [5:0] fn, input logic [1:0] rs,
                                          input logic [1:0] rt, input logic [1:0] rd);
        return {4'hf, rs, rt, rd, fn};
    endfunction

    // ISA-level interpreter of the loaded program
    function automatic void model_program();
        logic [15:0] r [4];
        logic [15:0] pc, cur, ins, a, b, imm, addr;
        logic [5:0]  fn;
        bit          done;
        exp_out.delete();
        exp_count = 0;
        for (int i = 0; i < 256; i++) exp_ram[i] = fill_word(i);
        for (int i = 0; i < 4; i++) r[i] = '0;
        pc = '0;
        done = 1'b0;
        while (!done && exp_count < 1024) begin
            cur = pc;
            ins = rom[cur[7:0]];
            a = r[ins[11:10]];
            b = r[ins[9:8]];
            imm = {{8{ins[7]}}, ins[7:0]};
            addr = a + imm;
            fn = ins[5:0];
            pc = cur + 16'd1;
            exp_count++;
            case (ins[15:12])
                OP_BNE: if (a != b) pc = pc + imm;
                OP_BEQ: if (a == b) pc = pc + imm;
                OP_ADI: r[ins[9:8]] = addr;
                OP_ORI: r[ins[9:8]] = a | {8'h00, ins[7:0]};
                OP_LHI: r[ins[9:8]] = {ins[7:0], 8'h00};
                OP_LWD: r[ins[9:8]] = exp_ram[addr[7:0]];
                OP_SWD: exp_ram[addr[7:0]] = b;
                OP_JMP, OP_JAL: begin
                    if (ins[15:12] == OP_JAL) r[link_reg] = pc;
                    pc = {cur[15:12], ins[11:0]};
                end
                OP_RTYPE: begin
                    case (fn)
                        FN_ADD: r[ins[7:6]] = a + b;
                        FN_SUB: r[ins[7:6]] = a - b;
                        FN_AND: r[ins[7:6]] = a & b;
                        FN_ORR: r[ins[7:6]] = a | b;
                        FN_NOT: r[ins[7:6]] = ~a;
                        FN_TCP: r[ins[7:6]] = 16'd0 - a;
                        FN_SHL: r[ins[7:6]] = a << 1;
                        FN_SHR: r[ins[7:6]] = $signed(a) >>> 1;
                        FN_JPR, FN_JRL: begin
                            if (fn == FN_JRL) r[link_reg] = pc;
                            pc = a;
                        end
                        FN_WWD: exp_out.push_back(a);
                        FN_HLT: done = 1'b1;
                        default: ;
                    endcase
                end
                default: ;  // unused opcodes do nothing
            endcase
        end
    endfunction

    task automatic new_program();
        plen = 0;
        for (int i = 0; i < 256; i++) rom[i] = {4'hb, 4'h0, 8'(i)};  // no-op filler
    endtask

    task automatic emit(input logic [15:0] ins);
        rom[plen] = ins;
        plen++;
    endtask

    task automatic load_random(input logic [1:0] rt);
        emit(itype(OP_LHI, 0, rt, rand_byte()));
        emit(itype(OP_ORI, rt, rt, rand_byte()));
    endtask

    task automatic memory_program();
        new_program();
        emit(itype(OP_LHI, 0, 0, 8'h00));
        emit(itype(OP_ORI, 0, 0, 8'h20));  // base address
        load_random(1);
        emit(itype(OP_SWD, 0, 1, 8'h00));
        emit(itype(OP_LWD, 0, 2, 8'h00));  // same word straight back
        emit(rtype(FN_WWD, 2, 0, 0));
        emit(itype(OP_ADI, 1, 1, 8'h01));
        emit(itype(OP_SWD, 0, 1, 8'h01));
        emit(itype(OP_LWD, 0, 3, 8'h02));
        emit(rtype(FN_WWD, 3, 0, 0));
        emit(itype(OP_LWD, 0, 3, 8'h01));
        emit(rtype(FN_WWD, 3, 0, 0));
        emit(itype(OP_SWD, 0, 3, 8'hff));  // negative offset
        emit(itype(OP_LWD, 0, 2, 8'hff));
        emit(rtype(FN_WWD, 2, 0, 0));
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic finish_program(input string name);
        test_name = name;
        emit(rtype(FN_HLT, 0, 0, 0));
        cycle_limit += plen * 4;
        model_program();
    endtask

    task automatic finish_checks();
        while (!is_halted) @(negedge clk);
        repeat (4) @(negedge clk);  // room for a stray wwd
        check("is_halted", 1, 32'(is_halted));
        check("wwd count", exp_out.size(), out_idx);
        check("num_inst", exp_count, 32'(num_inst));
        for (int i = 0; i < 256; i++) begin
            check($sformatf("ram[%0d]", i), 32'(exp_ram[i]), 32'(ram[i]));
        end
    endtask

    task automatic run_program(input string name);
        finish_program(name);
        apply_reset();
        finish_checks();
    endtask

    initial begin
        new_program();
        for (int k = 0; k < 3; k++) begin
            load_random(0);
            load_random(1);
            for (int f = 0; f < 8; f++) begin
                emit(rtype(6'(f), 0, 1, 3));
                emit(rtype(FN_WWD, 3, 0, 0));
            end
        end
        run_program("alu");

        new_program();
        load_random(1);
        emit(itype(OP_ADI, 1, 2, 8'h03));
        emit(rtype(FN_ADD, 2, 1, 3));
        emit(rtype(FN_SUB, 3, 2, 0));
        emit(rtype(FN_WWD, 0, 0, 0));
        emit(itype(OP_LHI, 0, 2, 8'h00));
        emit(itype(OP_ORI, 2, 2, 8'h10));
        emit(itype(OP_SWD, 2, 0, 8'h00));
        emit(itype(OP_LWD, 2, 3, 8'h00));
        emit(rtype(FN_WWD, 3, 0, 0));  // load then use
        emit(itype(OP_LWD, 2, 1, 8'h01));
        emit(rtype(FN_ADD, 1, 3, 1));
        emit(rtype(FN_WWD, 1, 0, 0));
        run_program("hazard");

        memory_program();
        run_program("memory");

        new_program();
        emit(itype(OP_LHI, 0, 0, rand_byte()));
        emit(itype(OP_ADI, 0, 1, 8'h00));
        emit(itype(OP_BEQ, 0, 1, 8'h01));  // taken
        emit(rtype(FN_WWD, 0, 0, 0));
        emit(itype(OP_BNE, 0, 1, 8'h01));  // not taken
        emit(rtype(FN_WWD, 1, 0, 0));
        emit(itype(OP_ADI, 1, 1, 8'h01));
        emit(itype(OP_BNE, 0, 1, 8'h02));
        emit(rtype(FN_WWD, 0, 0, 0));
        emit(itype(OP_ADI, 0, 0, 8'h07));
        emit(itype(OP_BEQ, 0, 1, 8'h01));
        emit({OP_JAL, 12'(plen + 2)});
        emit(rtype(FN_WWD, 0, 0, 0));
        emit(rtype(FN_WWD, 2, 0, 0));  // link from jal
        emit(itype(OP_LHI, 0, 3, 8'h00));
        emit(itype(OP_ORI, 3, 3, 8'(plen + 3)));
        emit(rtype(FN_JPR, 3, 0, 0));
        emit(rtype(FN_WWD, 3, 0, 0));
        emit(itype(OP_LHI, 0, 3, 8'h00));
        emit(itype(OP_ORI, 3, 3, 8'(plen + 3)));
        emit(rtype(FN_JRL, 3, 0, 0));
        emit(rtype(FN_WWD, 0, 0, 0));
        emit(rtype(FN_WWD, 2, 0, 0));  // link from jrl
        emit({OP_JMP, 12'(plen + 2)});
        emit(rtype(FN_WWD, 1, 0, 0));
        emit(rtype(FN_WWD, 0, 0, 0));
        run_program("branch");

        new_program();
        load_random(0);
        emit(rtype(FN_WWD, 0, 0, 0));
        emit(rtype(FN_HLT, 0, 0, 0));
        emit(rtype(FN_WWD, 0, 0, 0));
        emit(itype(OP_SWD, 1, 0, 8'h30));
        run_program("halt");

        memory_program();
        finish_program("reset");
        cycle_limit += plen * 4;  // runs twice
        apply_reset();
        while (out_idx == 0) @(negedge clk);
        while (!out_valid) @(negedge clk);
        rst_n = 1'b0;  // lands inside a wwd pulse
        #1;
        check("outputs in reset", 0, 32'({out_valid, dmem_rd, dmem_wr, is_halted}));
        check("num_inst in reset", 0, 32'(num_inst));
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        finish_checks();

        $display("Testbench passed");
        $finish;
    end

endmodule

/* sources.f */
source/cpu_pkg.sv
source/register_file.sv
source/alu.sv
source/control_unit.sv
source/hazard_unit.sv
source/pipeline_datapath.sv
source/cpu_top.sv
bench/cpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module cpu_tb -f sources.f -o cpu_sim

# pipeline status comes from tee, the log decides the result
./obj_dir/cpu_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"
